/* memPipe_settings.svh */
`ifndef MEM_PIPE_SETTINGS_SVH
`define MEM_PIPE_SETTINGS_SVH

// Data memory geometry in 32-bit words.
`define MEM_PIPE_DMEM_WORDS 64
`define MEM_PIPE_DMEM_AW 6

`endif

/* memPipeIsaPkg.sv */
package memPipeIsaPkg;

	typedef enum logic [3:0] {
		opAdd  = 4'h0, // Traps on signed overflow.
		opAddu = 4'h1,
		opLw   = 4'h2,
		opLh   = 4'h3,
		opLhu  = 4'h4,
		opLb   = 4'h5,
		opLbu  = 4'h6,
		opSw   = 4'h7,
		opSh   = 4'h8,
		opSb   = 4'h9
	} opT;

	// MIPS cause codes.
	typedef enum logic [4:0] {
		excInt  = 5'd0,
		excAdEL = 5'd4,
		excAdES = 5'd5,
		excSys  = 5'd8,
		excOv   = 5'd12
	} excCodeT;

	typedef struct packed {
		logic        valid;
		opT          op;
		logic [31:0] pc;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [15:0] imm;
		logic [4:0]  rd;
		logic        excIn; // Exception raised by an earlier stage.
		excCodeT     excInCode;
	} issueT;

endpackage

/* memPipeStagePkg.sv */
package memPipeStagePkg;

	typedef struct packed {
		logic                  valid;
		memPipeIsaPkg::opT     op;
		logic [31:0]           pc;
		logic [4:0]            rd;
		logic [31:0]           aluOut; // Sum or effective address.
		logic [31:0]           storeData;
		logic                  overflow;
		logic                  excIn;
		memPipeIsaPkg::excCodeT excInCode;
	} exStageT;

	typedef struct packed {
		logic                  valid;
		memPipeIsaPkg::opT     op;
		logic [31:0]           pc;
		logic [4:0]            rd;
		logic [31:0]           aluOut;
		logic [31:0]           storeData;
		logic                  exc;
		memPipeIsaPkg::excCodeT excCode;
		logic [31:0]           badVAddr;
	} memEntryT;

	typedef struct packed {
		logic        valid;
		logic [4:0]  rd;
		logic [31:0] pc;
		logic [31:0] data;
	} wbT;

	// Exception report toward CP0.
	typedef struct packed {
		logic                  valid;
		memPipeIsaPkg::excCodeT code;
		logic [31:0]           epc;
		logic [31:0]           badVAddr;
	} excT;

endpackage

/* execUnit.sv */
`timescale 1ns/1ps

module execUnit (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     flush,
	input  memPipeIsaPkg::issueT     issue,
	output memPipeStagePkg::exStageT exStage
);

	memPipeIsaPkg::issueT idEx;

	logic [31:0] immExt;
	logic [31:0] operandB;
	logic [31:0] sum;
	logic        isAddOp;
	logic        addOverflow;

	// ID/EX register.
	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			idEx <= '0;
		end else begin
			idEx <= issue;
		end
	end

	assign immExt = {{16{idEx.imm[15]}}, idEx.imm};

	assign isAddOp = (idEx.op == memPipeIsaPkg::opAdd) ||
		(idEx.op == memPipeIsaPkg::opAddu);

	// Memory ops use base plus offset.
	assign operandB = isAddOp ? idEx.rtVal : immExt;
	assign sum = idEx.rsVal + operandB;

	// Same operand signs, different result sign.
	assign addOverflow = (idEx.rsVal[31] == operandB[31]) && (sum[31] != idEx.rsVal[31]);

	always_comb begin
		exStage.valid     = idEx.valid;
		exStage.op        = idEx.op;
		exStage.pc        = idEx.pc;
		exStage.rd        = idEx.rd;
		exStage.aluOut    = sum;
		exStage.storeData = idEx.rtVal;
		exStage.overflow  = addOverflow && (idEx.op == memPipeIsaPkg::opAdd); // Trapping add only.
		exStage.excIn     = idEx.excIn;
		exStage.excInCode = idEx.excInCode;
	end

endmodule

/* exMemReg.sv */
`timescale 1ns/1ps

module exMemReg (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      flush,
	input  memPipeStagePkg::exStageT  exStage,
	output memPipeStagePkg::memEntryT memEntry
);

	memPipeStagePkg::memEntryT nxt;

	logic storeMisaligned;
	logic loadMisaligned;

	assign storeMisaligned =
		((exStage.op == memPipeIsaPkg::opSw) && (exStage.aluOut[1:0] != 2'b00)) ||
		((exStage.op == memPipeIsaPkg::opSh) && exStage.aluOut[0]);

	assign loadMisaligned =
		((exStage.op == memPipeIsaPkg::opLw) && (exStage.aluOut[1:0] != 2'b00)) ||
		((exStage.op == memPipeIsaPkg::opLh || exStage.op == memPipeIsaPkg::opLhu) &&
			exStage.aluOut[0]);

	// Fixed priority, earliest stage first.
	always_comb begin
		nxt.valid     = exStage.valid;
		nxt.op        = exStage.op;
		nxt.pc        = exStage.pc;
		nxt.rd        = exStage.rd;
		nxt.aluOut    = exStage.aluOut;
		nxt.storeData = exStage.storeData;
		nxt.exc       = exStage.valid;
		nxt.excCode   = memPipeIsaPkg::excInt;
		nxt.badVAddr  = exStage.pc;
		if (!exStage.valid) begin
			nxt.badVAddr = '0;
		end else if (exStage.excIn) begin
			nxt.excCode = exStage.excInCode;
		end else if (exStage.overflow) begin
			nxt.excCode = memPipeIsaPkg::excOv;
		end else if (storeMisaligned) begin
			nxt.excCode  = memPipeIsaPkg::excAdES;
			nxt.badVAddr = exStage.aluOut;
		end else if (loadMisaligned) begin
			nxt.excCode  = memPipeIsaPkg::excAdEL;
			nxt.badVAddr = exStage.aluOut;
		end else begin
			nxt.exc      = 1'b0; // Clean instruction.
			nxt.badVAddr = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			memEntry <= '0;
		end else begin
			memEntry <= nxt;
		end
	end

endmodule

/* memStage.sv */
`timescale 1ns/1ps
`include "memPipe_settings.svh"

module memStage (
	input  logic                      clk,
	input  logic                      rst,
	input  memPipeStagePkg::memEntryT memEntry,
	output logic                      flush,
	output memPipeStagePkg::wbT       wb,
	output memPipeStagePkg::excT      exc
);

	logic [31:0] dmem [`MEM_PIPE_DMEM_WORDS];

	logic [`MEM_PIPE_DMEM_AW-1:0] wordIdx;
	logic [1:0]  byteOff;
	logic [31:0] rdWord;
	logic [7:0]  rdByte;
	logic [15:0] rdHalf;
	logic [31:0] wbData;
	logic [31:0] wrData;
	logic [3:0]  byteEn;
	logic        isStore;
	logic        clean;
	logic        doStore;

	assign wordIdx = memEntry.aluOut[`MEM_PIPE_DMEM_AW+1:2]; // Wraps at 256 bytes.
	assign byteOff = memEntry.aluOut[1:0];

	assign isStore = (memEntry.op == memPipeIsaPkg::opSw) ||
		(memEntry.op == memPipeIsaPkg::opSh) || (memEntry.op == memPipeIsaPkg::opSb);
	assign clean   = memEntry.valid && !memEntry.exc;
	assign doStore = clean && isStore;

	// Excepting entry squashes the younger stages.
	assign flush = memEntry.valid && memEntry.exc;

	// Little-endian byte lanes.
	always_comb begin
		case (memEntry.op)
			memPipeIsaPkg::opSh: begin
				byteEn = byteOff[1] ? 4'b1100 : 4'b0011;
				wrData = {2{memEntry.storeData[15:0]}};
			end
			memPipeIsaPkg::opSb: begin
				byteEn = 4'b0001 << byteOff;
				wrData = {4{memEntry.storeData[7:0]}};
			end
			default: begin
				byteEn = 4'b1111;
				wrData = memEntry.storeData;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (doStore) begin
			for (int i = 0; i < 4; i++) begin
				if (byteEn[i]) dmem[wordIdx][8*i +: 8] <= wrData[8*i +: 8];
			end
		end
	end

	assign rdWord = dmem[wordIdx];
	assign rdByte = rdWord[8*byteOff +: 8];
	assign rdHalf = byteOff[1] ? rdWord[31:16] : rdWord[15:0];

	always_comb begin
		case (memEntry.op)
			memPipeIsaPkg::opLw:  wbData = rdWord;
			memPipeIsaPkg::opLh:  wbData = {{16{rdHalf[15]}}, rdHalf};
			memPipeIsaPkg::opLhu: wbData = {16'h0000, rdHalf};
			memPipeIsaPkg::opLb:  wbData = {{24{rdByte[7]}}, rdByte};
			memPipeIsaPkg::opLbu: wbData = {24'h000000, rdByte};
			default:              wbData = memEntry.aluOut; // Add results.
		endcase
	end

	// MEM/WB register and exception capture.
	always_ff @(posedge clk) begin
		if (!rst) begin
			wb  <= '0;
			exc <= '0;
		end else begin
			wb.valid     <= clean && !isStore;
			wb.rd        <= memEntry.rd;
			wb.pc        <= memEntry.pc;
			wb.data      <= wbData;
			exc.valid    <= flush; // One-cycle pulse.
			exc.code     <= memEntry.excCode;
			exc.epc      <= memEntry.pc;
			exc.badVAddr <= memEntry.badVAddr;
		end
	end

endmodule

/* memPipe.sv */
`timescale 1ns/1ps

module memPipe (
	input  logic                 clk,
	input  logic                 rst,
	input  memPipeIsaPkg::issueT issue,
	output memPipeStagePkg::wbT  wb,
	output memPipeStagePkg::excT exc
);

	memPipeStagePkg::exStageT  exStage;
	memPipeStagePkg::memEntryT memEntry;
	logic                      flush;

	execUnit i_execUnit (
		.clk     (clk),
		.rst     (rst),
		.flush   (flush),
		.issue   (issue),
		.exStage (exStage)
	);

	exMemReg i_exMemReg (
		.clk      (clk),
		.rst      (rst),
		.flush    (flush),
		.exStage  (exStage),
		.memEntry (memEntry)
	);

	// Flush comes back from the memory stage.
	memStage i_memStage (
		.clk      (clk),
		.rst      (rst),
		.memEntry (memEntry),
		.flush    (flush),
		.wb       (wb),
		.exc      (exc)
	);

endmodule

/* memPipe_assertions.sv */
`timescale 1ns/1ps

module memPipeAssertions (
	input logic                 clk,
	input logic                 rst,
	input logic                 flush,
	input memPipeStagePkg::wbT  wb,
	input memPipeStagePkg::excT exc
);

	int failCount = 0;

	// Every flush reports on the next edge and clears the EX/MEM entry behind it.
	flushReports: assert property (@(posedge clk) disable iff (!rst)
		flush |=> (exc.valid && !flush))
		else begin
			$error("flush was not followed by an exception report, or it stayed high");
			failCount++;
		end

	oneResult: assert property (@(posedge clk) disable iff (!rst) !(wb.valid && exc.valid))
		else begin
			$error("wb and exc valid at the same time");
			failCount++;
		end

	resetQuiet: assert property (@(posedge clk) !rst |=> (!wb.valid && !exc.valid))
		else begin
			$error("result valid while in reset");
			failCount++;
		end

endmodule

bind memStage memPipeAssertions i_memPipeAssertions (.*);

/* memPipeTb.sv */
`timescale 1ns/1ps
`include "memPipe_settings.svh"

module memPipeTb;

	typedef struct packed {
		memPipeStagePkg::wbT  wb;
		memPipeStagePkg::excT exc;
	} expT;

	// Instructions, bubbles and drain slots of all tests.
	localparam int issueSlots = 64 + 6 + 13 + 22 + 4 + 300 + 6 * 11;
	localparam int cycleLimit = issueSlots + 50;

	logic clk;
	logic rst;
	memPipeIsaPkg::issueT issue;
	memPipeStagePkg::wbT  wb;
	memPipeStagePkg::excT exc;

	logic [31:0] modelMem [`MEM_PIPE_DMEM_WORDS];
	expT         expQ [$];
	logic [31:0] pcNext;
	int          squashLeft;
	int          errCount;
	int          testErrBase;
	int          checkCount;
	int          testsPassed;
	int          testsFailed;
	int          cycleCount;

	memPipe i_memPipe (.clk(clk), .rst(rst), .issue(issue), .wb(wb), .exc(exc));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic memPipeIsaPkg::issueT makeIssue(input memPipeIsaPkg::opT op,
			input logic [31:0] rs, input logic [31:0] rt, input logic [15:0] imm,
			input logic excIn);
		memPipeIsaPkg::issueT ins;
		ins = '0;
		ins.valid = 1'b1;
		ins.op = op;
		ins.rsVal = rs;
		ins.rtVal = rt;
		ins.imm = imm;
		ins.excIn = excIn;
		ins.excInCode = memPipeIsaPkg::excSys;
		return ins;
	endfunction

	function automatic logic [31:0] mergeStore(input logic [31:0] old,
			input memPipeIsaPkg::opT op, input logic [1:0] off, input logic [31:0] d);
		logic [31:0] w;
		w = old;
		if (op == memPipeIsaPkg::opSw) w = d;
		else if (op == memPipeIsaPkg::opSh) w[16*off[1] +: 16] = d[15:0];
		else w[8*off +: 8] = d[7:0];
		return w;
	endfunction

	// Expected wb or exc record for one surviving instruction.
	function automatic expT predict(input memPipeIsaPkg::issueT ins,
			input logic [31:0] mem [`MEM_PIPE_DMEM_WORDS]);
		expT         e;
		logic [31:0] addr;
		logic [31:0] sum;
		logic [31:0] word;
		logic [15:0] half;
		logic [7:0]  bt;
		longint      wide;
		e = '0;
		addr = ins.rsVal + {{16{ins.imm[15]}}, ins.imm};
		sum = ins.rsVal + ins.rtVal;
		wide = longint'($signed(ins.rsVal)) + longint'($signed(ins.rtVal));
		word = mem[addr[`MEM_PIPE_DMEM_AW+1:2]];
		half = addr[1] ? word[31:16] : word[15:0];
		bt = 8'(word >> (8 * addr[1:0]));
		e.exc.valid = 1'b1;
		e.exc.epc = ins.pc;
		e.exc.badVAddr = ins.pc;
		if (ins.excIn) begin
			e.exc.code = ins.excInCode;
		end else if (ins.op == memPipeIsaPkg::opAdd && wide != longint'($signed(sum))) begin
			e.exc.code = memPipeIsaPkg::excOv;
		end else if ((ins.op == memPipeIsaPkg::opSw && addr[1:0] != 2'b00) ||
				(ins.op == memPipeIsaPkg::opSh && addr[0])) begin
			e.exc.code = memPipeIsaPkg::excAdES;
			e.exc.badVAddr = addr;
		end else if ((ins.op == memPipeIsaPkg::opLw && addr[1:0] != 2'b00) ||
				((ins.op == memPipeIsaPkg::opLh || ins.op == memPipeIsaPkg::opLhu) && addr[0])) begin
			e.exc.code = memPipeIsaPkg::excAdEL;
			e.exc.badVAddr = addr;
		end else begin
			e.exc = '0;
			e.wb.valid = ins.op < memPipeIsaPkg::opSw; // Stores write nothing back.
			e.wb.rd = ins.rd;
			e.wb.pc = ins.pc;
			case (ins.op)
				memPipeIsaPkg::opLw:  e.wb.data = word;
				memPipeIsaPkg::opLh:  e.wb.data = {{16{half[15]}}, half};
				memPipeIsaPkg::opLhu: e.wb.data = {16'h0000, half};
				memPipeIsaPkg::opLb:  e.wb.data = {{24{bt[7]}}, bt};
				memPipeIsaPkg::opLbu: e.wb.data = {24'h000000, bt};
				default:              e.wb.data = sum;
			endcase
		end
		return e;
	endfunction

	task automatic sendIssue(input memPipeIsaPkg::issueT ins);
		expT         e;
		logic [31:0] addr;
		@(posedge clk);
		if (ins.valid) begin
			ins.pc = pcNext;
			ins.rd = pcNext[6:2];
			pcNext += 4;
		end
		issue <= ins;
		if (squashLeft > 0) begin
			squashLeft--; // Killed by the flush of an older exception.
		end else if (ins.valid) begin
			e = predict(ins, modelMem);
			addr = ins.rsVal + {{16{ins.imm[15]}}, ins.imm};
			if (e.exc.valid) squashLeft = 2;
			else if (ins.op >= memPipeIsaPkg::opSw)
				modelMem[addr[`MEM_PIPE_DMEM_AW+1:2]] =
					mergeStore(modelMem[addr[`MEM_PIPE_DMEM_AW+1:2]], ins.op, addr[1:0], ins.rtVal);
			if (e.wb.valid || e.exc.valid) expQ.push_back(e);
		end
	endtask

	task automatic compareField(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			$display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
			errCount++;
		end
	endtask

	always @(negedge clk) begin
		expT e;
		if (rst && (wb.valid || exc.valid)) begin
			if (expQ.size() == 0) begin
				$display("ERROR: the DUT produced a result that no instruction should have made");
				errCount++;
			end else begin
				e = expQ.pop_front();
				compareField("wb.valid", wb.valid, e.wb.valid);
				compareField("exc.valid", exc.valid, e.exc.valid);
				if (e.wb.valid) begin
					compareField("wb.rd", wb.rd, e.wb.rd);
					compareField("wb.pc", wb.pc, e.wb.pc);
					compareField("wb.data", wb.data, e.wb.data);
				end else begin
					compareField("exc.code", 32'(exc.code), 32'(e.exc.code));
					compareField("exc.epc", exc.epc, e.exc.epc);
					compareField("exc.badVAddr", exc.badVAddr, e.exc.badVAddr);
				end
			end
		end
	end

	task automatic endTest(input string name);
		int guard;
		guard = 0;
		while (expQ.size() != 0 && guard < 8) begin
			sendIssue('0);
			guard++;
		end
		repeat (3) sendIssue('0);
		if (expQ.size() != 0) begin
			$display("ERROR: %0d expected results never came out in test %s", expQ.size(), name);
			errCount++;
			expQ.delete();
		end
		if (errCount == testErrBase) begin
			testsPassed++;
			$display("Test %s: ok", name);
		end else begin
			testsFailed++;
			$display("Test %s: %0d errors", name, errCount - testErrBase);
		end
		testErrBase = errCount;
	endtask

	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("ERROR: timeout, the run did not finish within %0d cycles", cycleLimit);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		memPipeIsaPkg::issueT ins;
		memPipeIsaPkg::opT    op;
		void'($urandom(32'he99a));
		pcNext = 32'h00400000;
		squashLeft = 0;
		rst = 1'b0;
		issue = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;

		for (int i = 0; i < `MEM_PIPE_DMEM_WORDS; i++)
			sendIssue(makeIssue(memPipeIsaPkg::opSw, 32'(4 * i),
				{2'b10, 6'(i), 2'b01, ~(6'(i)), 8'(7 * i), 8'(i) ^ 8'h3c}, 16'h0, 1'b0));
		endTest("memory fill");

		sendIssue(makeIssue(memPipeIsaPkg::opAddu, 32'h1, 32'h2, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opAddu, 32'hffffffff, 32'h1, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opAdd, 32'h7fffffff, 32'h0, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opAdd, 32'h80000000, 32'h7fffffff, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opAdd, 32'hffffffff, 32'h80000001, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opAdd, 32'h40000000, 32'h3fffffff, 16'h0, 1'b0));
		endTest("arithmetic");

		sendIssue(makeIssue(memPipeIsaPkg::opSw, 32'h40, 32'h80817f7e, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opSh, 32'h50, 32'h12349abc, 16'hfff6, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opSb, 32'h45, 32'h000000f0, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opLw, 32'h40, 32'h0, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opLh, 32'h40, 32'h0, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opLh, 32'h40, 32'h0, 16'h2, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opLhu, 32'h42, 32'h0, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opLb, 32'h41, 32'h0, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opLb, 32'h43, 32'h0, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opLbu, 32'h43, 32'h0, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opLw, 32'h48, 32'h0, 16'hfffc, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opLbu, 32'h45, 32'h0, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opLh, 32'h46, 32'h0, 16'h0, 1'b0));
		endTest("loads and stores");

		// Two bubbles after each so the next one survives the flush.
		sendIssue(makeIssue(memPipeIsaPkg::opAdd, 32'h7fffffff, 32'h1, 16'h0, 1'b0));
		repeat (2) sendIssue('0);
		sendIssue(makeIssue(memPipeIsaPkg::opSw, 32'h22, 32'hdeadbeef, 16'h0, 1'b0));
		repeat (2) sendIssue('0);
		sendIssue(makeIssue(memPipeIsaPkg::opLw, 32'h20, 32'h0, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opSh, 32'h31, 32'h5555, 16'h0, 1'b0));
		repeat (2) sendIssue('0);
		sendIssue(makeIssue(memPipeIsaPkg::opLw, 32'h13, 32'h0, 16'h0, 1'b0));
		repeat (2) sendIssue('0);
		sendIssue(makeIssue(memPipeIsaPkg::opLhu, 32'h17, 32'h0, 16'h0, 1'b0));
		repeat (2) sendIssue('0);
		sendIssue(makeIssue(memPipeIsaPkg::opAdd, 32'h7fffffff, 32'h1, 16'h0, 1'b1));
		repeat (2) sendIssue('0);
		sendIssue(makeIssue(memPipeIsaPkg::opLw, 32'h13, 32'h0, 16'h0, 1'b1));
		repeat (2) sendIssue('0);
		endTest("exceptions");

		sendIssue(makeIssue(memPipeIsaPkg::opAdd, 32'h7fffffff, 32'h7fffffff, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opSw, 32'h60, 32'h11111111, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opAddu, 32'h5, 32'h6, 16'h0, 1'b0));
		sendIssue(makeIssue(memPipeIsaPkg::opLw, 32'h60, 32'h0, 16'h0, 1'b0));
		endTest("flush squash");

		for (int n = 0; n < 300; n++) begin
			op = memPipeIsaPkg::opT'(4'($urandom_range(9, 0)));
			ins = makeIssue(op, $urandom, $urandom, 16'($urandom_range(31, 0)) - 16'd16,
				$urandom_range(19, 0) == 0);
			if (op > memPipeIsaPkg::opAddu) ins.rsVal = $urandom_range(255, 0);
			if ($urandom_range(1, 0) == 1) ins.excInCode = memPipeIsaPkg::excAdEL;
			sendIssue(ins);
		end
		endTest("random mix");

		$display("Tests passed %0d, failed %0d, field checks %0d", testsPassed, testsFailed,
			checkCount);
		if (testsFailed == 0 && i_memPipe.i_memStage.i_memPipeAssertions.failCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* memPipe.f */
+incdir+.
memPipeIsaPkg.sv
memPipeStagePkg.sv
execUnit.sv
exMemReg.sv
memStage.sv
memPipe.sv
memPipe_assertions.sv
memPipeTb.sv

/* Bender.yml */
package:
  name: memPipe

sources:
  - include_dirs:
      - .
    files:
      - memPipeIsaPkg.sv
      - memPipeStagePkg.sv
      - execUnit.sv
      - exMemReg.sv
      - memStage.sv
      - memPipe.sv
  - target: test
    include_dirs:
      - .
    files:
      - memPipe_assertions.sv
      - memPipeTb.sv
